// File: hw/nice_string_pkg.sv
`default_nettype none

package nice_string_pkg;

    // ==================================================
    // character codes and widths
    // ==================================================

    localparam int CHAR_WIDTH = 8;
    localparam int LETTER_COUNT = 26;

    // only the codes the trackers decode, values from the ASCII table
    typedef enum logic [CHAR_WIDTH-1:0] {
        CHAR_NULL = 8'h00,
        CHAR_LF   = 8'h0A,
        CHAR_A    = 8'h61,
        CHAR_Z    = 8'h7A
    } char_t;

    // per-line result, both bits valid alongside string_valid
    typedef struct packed {
        logic has_repeating_char;
        logic has_double_pair;
    } string_flags_t;

    function automatic logic is_letter(input logic [CHAR_WIDTH-1:0] code);
        return (code >= CHAR_A) && (code <= CHAR_Z);
    endfunction

endpackage

`default_nettype wire

// File: hw/repeating_char_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module repeating_char_tracker (
    input wire clk,
    input wire reset,
    input wire inbound_valid,
    input wire [nice_string_pkg::CHAR_WIDTH-1:0] inbound_data,
    output logic end_of_file,
    output logic has_repeating_char,
    output logic string_valid
);

    // entry 0 is the newest accepted character, entry 1 the one before it
    logic [1:0][nice_string_pkg::CHAR_WIDTH-1:0] char_history;
    logic completes_repeat;

    // ==================================================
    // character history
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            char_history <= {nice_string_pkg::CHAR_NULL, nice_string_pkg::CHAR_NULL};
        end else if (inbound_valid) begin
            char_history <= {char_history[0], inbound_data};
        end
    end

    // a line feed or NUL in the history is not a letter, so matches never
    // reach across a line boundary
    assign completes_repeat = nice_string_pkg::is_letter(inbound_data) &&
                              nice_string_pkg::is_letter(char_history[0]) &&
                              nice_string_pkg::is_letter(char_history[1]) &&
                              (inbound_data == char_history[1]);

    // ==================================================
    // x?x flag
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            has_repeating_char <= 1'b0;
        end else begin
            if (string_valid) begin
                has_repeating_char <= 1'b0;
            end
            // a letter landing on the clearing edge still sets the flag
            if (inbound_valid && completes_repeat) begin
                has_repeating_char <= 1'b1;
            end
        end
    end

    // ==================================================
    // line framing
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            end_of_file <= 1'b0;
            string_valid <= 1'b0;
        end else begin
            string_valid <= 1'b0;
            if (inbound_valid) begin
                unique case (inbound_data)
                    nice_string_pkg::CHAR_NULL: begin
                        end_of_file <= 1'b1;
                    end
                    nice_string_pkg::CHAR_LF: begin
                        string_valid <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // one pulse per line feed, lines are never empty
    string_valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        string_valid |=> !string_valid
    );

endmodule

`default_nettype wire

// File: hw/letter_pair_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module letter_pair_tracker (
    input wire clk,
    input wire reset,
    input wire inbound_valid,
    input wire [nice_string_pkg::CHAR_WIDTH-1:0] inbound_data,
    input wire string_valid,
    output logic has_double_pair
);

    localparam int PAIR_COUNT = nice_string_pkg::LETTER_COUNT * nice_string_pkg::LETTER_COUNT;
    localparam int PAIR_INDEX_WIDTH = $clog2(PAIR_COUNT);

    typedef logic [PAIR_INDEX_WIDTH-1:0] pair_index_t;

    logic [nice_string_pkg::CHAR_WIDTH-1:0] prev_char;
    logic [PAIR_COUNT-1:0] seen_pairs;
    logic pending_valid;
    pair_index_t pending_index;

    logic cur_is_pair;
    pair_index_t cur_index;
    logic cur_seen;

    // index is first letter times 26 plus second letter
    function automatic pair_index_t pair_index(
        input logic [nice_string_pkg::CHAR_WIDTH-1:0] first,
        input logic [nice_string_pkg::CHAR_WIDTH-1:0] second
    );
        pair_index_t first_off;
        pair_index_t second_off;
        first_off = PAIR_INDEX_WIDTH'(first - nice_string_pkg::CHAR_A);
        second_off = PAIR_INDEX_WIDTH'(second - nice_string_pkg::CHAR_A);
        return PAIR_INDEX_WIDTH'(first_off * nice_string_pkg::LETTER_COUNT + second_off);
    endfunction

    // ==================================================
    // current pair lookup
    // ==================================================

    assign cur_is_pair = nice_string_pkg::is_letter(prev_char) &&
                         nice_string_pkg::is_letter(inbound_data);
    assign cur_index = pair_index(prev_char, inbound_data);

    // the index is only in range for a letter pair
    assign cur_seen = cur_is_pair ? seen_pairs[cur_index] : 1'b0;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_char <= nice_string_pkg::CHAR_NULL;
        end else if (inbound_valid) begin
            prev_char <= inbound_data;
        end
    end

    // ==================================================
    // seen set with one character of insert delay
    // ==================================================

    // the pair ending at the previous character goes into the set only now,
    // so "aaa" finds nothing while "aaaa" matches the first pair
    always_ff @(posedge clk) begin
        if (reset) begin
            seen_pairs <= '0;
            pending_valid <= 1'b0;
            pending_index <= '0;
        end else begin
            if (string_valid) begin
                seen_pairs <= '0;
                pending_valid <= 1'b0;
            end
            if (inbound_valid) begin
                if (pending_valid) begin
                    seen_pairs[pending_index] <= 1'b1;
                end
                pending_valid <= cur_is_pair;
                pending_index <= cur_index;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            has_double_pair <= 1'b0;
        end else begin
            if (string_valid) begin
                has_double_pair <= 1'b0;
            end
            if (inbound_valid && cur_seen) begin
                has_double_pair <= 1'b1;
            end
        end
    end

    // the framing pulse always comes right after a line feed on this same byte stream
    pulse_follows_separator: assert property (
        @(posedge clk) disable iff (reset)
        string_valid |-> !nice_string_pkg::is_letter(prev_char)
    );

endmodule

`default_nettype wire

// File: hw/nice_string_counter.sv
`timescale 1ns/1ps
`default_nettype none

module nice_string_counter #(
    parameter int COUNT_WIDTH = 16
) (
    input wire clk,
    input wire reset,
    input wire string_valid,
    input wire nice_string_pkg::string_flags_t string_flags,
    input wire end_of_file,
    output logic [COUNT_WIDTH-1:0] nice_count,
    output logic done
);

    logic line_is_nice;
    logic count_full;

    assign line_is_nice = string_valid &&
                          string_flags.has_repeating_char &&
                          string_flags.has_double_pair;

    assign count_full = (nice_count == {COUNT_WIDTH{1'b1}});

    // ==================================================
    // line count
    // ==================================================

    // lines framed after the NUL are ignored, the count holds at all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            nice_count <= '0;
        end else if (line_is_nice && !end_of_file && !count_full) begin
            nice_count <= nice_count + 1'b1;
        end
    end

    // ==================================================
    // completion
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (end_of_file) begin
            done <= 1'b1;
        end
    end

    // once done is shown the count is final
    count_frozen_after_done: assert property (
        @(posedge clk) disable iff (reset)
        done |=> $stable(nice_count)
    );

endmodule

`default_nettype wire

// File: hw/nice_string_top.sv
`timescale 1ns/1ps
`default_nettype none

module nice_string_top #(
    parameter int COUNT_WIDTH = 16
) (
    input wire clk,
    input wire reset,
    input wire inbound_valid,
    input wire [nice_string_pkg::CHAR_WIDTH-1:0] inbound_data,
    output logic string_valid,
    output nice_string_pkg::string_flags_t string_flags,
    output logic [COUNT_WIDTH-1:0] nice_count,
    output logic done
);

    logic end_of_file;
    logic has_repeating_char;
    logic has_double_pair;

    // ==================================================
    // per-line trackers
    // ==================================================

    // framing comes from this block only, the pair tracker follows its pulse
    repeating_char_tracker repeating_char_tracker0 (
        .clk                (clk),
        .reset              (reset),
        .inbound_valid      (inbound_valid),
        .inbound_data       (inbound_data),
        .end_of_file        (end_of_file),
        .has_repeating_char (has_repeating_char),
        .string_valid       (string_valid)
    );

    letter_pair_tracker letter_pair_tracker0 (
        .clk             (clk),
        .reset           (reset),
        .inbound_valid   (inbound_valid),
        .inbound_data    (inbound_data),
        .string_valid    (string_valid),
        .has_double_pair (has_double_pair)
    );

    assign string_flags = '{has_repeating_char: has_repeating_char,
                            has_double_pair: has_double_pair};

    // ==================================================
    // result
    // ==================================================

    nice_string_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) nice_string_counter0 (
        .clk          (clk),
        .reset        (reset),
        .string_valid (string_valid),
        .string_flags (string_flags),
        .end_of_file  (end_of_file),
        .nice_count   (nice_count),
        .done         (done)
    );

endmodule

`default_nettype wire

// File: verification/nice_string_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nice_string_tb;

    localparam int COUNT_WIDTH = 16;
    localparam int CLK_PERIOD = 10;
    localparam int MAX_LEN = 16;
    localparam int RANDOM_LINES = 200;
    localparam int EXTRA_LINES = 3;
    // directed lines fit in the same per-line budget as random ones
    localparam int MAX_BYTES = (RANDOM_LINES + EXTRA_LINES + 5) * (MAX_LEN + 1) + 1;
    localparam int WATCHDOG_NS = MAX_BYTES * 5 * CLK_PERIOD + 200 * CLK_PERIOD;

    logic clk = 1'b0;
    logic reset;
    logic inbound_valid;
    logic [nice_string_pkg::CHAR_WIDTH-1:0] inbound_data;
    logic string_valid;
    nice_string_pkg::string_flags_t string_flags;
    logic [COUNT_WIDTH-1:0] nice_count;
    logic done;

    logic [31:0] lfsr_state;
    logic [7:0] line_buf [MAX_LEN];
    int line_len;
    bit gaps_on;
    bit eof_sent;
    bit done_seen;
    int expected_nice;
    int line_idx;
    nice_string_pkg::string_flags_t expected_q[$];
    nice_string_pkg::string_flags_t flags_popped;

    nice_string_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .inbound_valid (inbound_valid),
        .inbound_data  (inbound_data),
        .string_valid  (string_valid),
        .string_flags  (string_flags),
        .nice_count    (nice_count),
        .done          (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%0d ns %s", $time, reason);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // x?x and a non-overlapping repeated pair, lines hold letters only
    function automatic nice_string_pkg::string_flags_t expected_flags(
        input logic [7:0] text [MAX_LEN],
        input int len
    );
        nice_string_pkg::string_flags_t flags;
        int i;
        int j;
        flags = '0;
        for (i = 0; i + 2 < len; i++) begin
            if (text[i] == text[i+2]) begin
                flags.has_repeating_char = 1'b1;
            end
        end
        for (i = 0; i + 1 < len; i++) begin
            for (j = i + 2; j + 1 < len; j++) begin
                if (text[i] == text[j] && text[i+1] == text[j+1]) begin
                    flags.has_double_pair = 1'b1;
                end
            end
        end
        return flags;
    endfunction

    task automatic send_byte(input logic [7:0] code);
        int gap;
        inbound_valid = 1'b1;
        inbound_data = code;
        @(negedge clk);
        gap = 0;
        if (gaps_on) begin
            draw_bits(2, gap);
        end
        if (gap > 0) begin
            inbound_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic load_text(input string text);
        int i;
        line_len = text.len();
        for (i = 0; i < line_len; i++) begin
            line_buf[i] = text[i];
        end
    endtask

    task automatic build_random_line();
        int len_pick;
        int letter_pick;
        int i;
        draw_bits(4, len_pick);
        line_len = 3 + (len_pick % 14);
        for (i = 0; i < line_len; i++) begin
            draw_bits(3, letter_pick);
            line_buf[i] = nice_string_pkg::CHAR_A + 8'(letter_pick % 5);
        end
    endtask

    task automatic send_line();
        nice_string_pkg::string_flags_t flags;
        int i;
        flags = expected_flags(line_buf, line_len);
        expected_q.push_back(flags);
        if (!eof_sent && flags.has_repeating_char && flags.has_double_pair) begin
            expected_nice++;
        end
        for (i = 0; i < line_len; i++) begin
            send_byte(line_buf[i]);
        end
        send_byte(nice_string_pkg::CHAR_LF);
    endtask

    // ==================================================
    // compare and watchdog
    // ==================================================

    // outputs only move on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset) begin
            if (done) begin
                done_seen = 1'b1;
            end else if (done_seen) begin
                abort_run("done fell after it had risen");
            end
            if (string_valid) begin
                if (expected_q.size() == 0) begin
                    abort_run("string_valid pulsed with no line feed outstanding");
                end else begin
                    flags_popped = expected_q.pop_front();
                    check_value("string_flags.has_repeating_char",
                                32'(string_flags.has_repeating_char),
                                32'(flags_popped.has_repeating_char));
                    check_value("string_flags.has_double_pair",
                                32'(string_flags.has_double_pair),
                                32'(flags_popped.has_double_pair));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: done never rose");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        reset = 1'b1;
        inbound_valid = 1'b0;
        inbound_data = '0;
        lfsr_state = 32'h46d2c143;
        gaps_on = 1'b0;
        eof_sent = 1'b0;
        done_seen = 1'b0;
        expected_nice = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("string_valid", 32'(string_valid), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("string_flags", 32'(string_flags), 32'd0);
        check_value("nice_count", 32'(nice_count), 32'd0);

        // directed lines go back to back with no idle cycles
        load_text("aaa");
        send_line();
        load_text("aaaa");
        send_line();
        load_text("xyxy");
        send_line();
        load_text("aabcdefgaa");
        send_line();
        load_text("ieodomkazucvgmuy");
        send_line();

        gaps_on = 1'b1;
        for (line_idx = 0; line_idx < RANDOM_LINES; line_idx++) begin
            build_random_line();
            send_line();
        end
        send_byte(nice_string_pkg::CHAR_NULL);
        eof_sent = 1'b1;
        inbound_valid = 1'b0;

        while (!done) begin
            @(negedge clk);
        end
        if (expected_q.size() != 0) begin
            abort_run($sformatf("done rose with %0d lines still expected", expected_q.size()));
        end
        check_value("nice_count", 32'(nice_count), 32'(expected_nice));

        // lines after the NUL are framed but never counted
        for (line_idx = 0; line_idx < EXTRA_LINES; line_idx++) begin
            build_random_line();
            send_line();
        end
        inbound_valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check_value("nice_count", 32'(nice_count), 32'(expected_nice));
        check_value("done", 32'(done), 32'd1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: nice_string.f
hw/nice_string_pkg.sv
hw/repeating_char_tracker.sv
hw/letter_pair_tracker.sv
hw/nice_string_counter.sv
hw/nice_string_top.sv
verification/nice_string_tb.sv

// File: Makefile
# Verilator flow for the nice string classifier
# every variable below can be overridden on the command line

TOP       ?= nice_string_tb
FLIST     ?= nice_string.f
VERILATOR ?= verilator
SEED      ?= 1
OBJ_DIR   ?= obj_dir

LINT_FLAGS ?= --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the testbench ends every failing run with $fatal, so the simulator
# exit status carries pass or fail back to make
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
